// ==== project.f ====
verilog/dcache_geom_pkg.sv
verilog/dcache_ctrl_pkg.sv
verilog/dcache_req_stage.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_props.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module dcache_tb \
   -f project.f -o dcache_sim > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

grep -q "All tests passed!" sim.log && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== dv/dcache_tb.sv ====
// ----------------------------------------------------------
// Data cache testbench: clock, reset, LFSR request stimulus
// and a randomly throttled line-burst memory responder
// ----------------------------------------------------------

module dcache_tb
   import dcache_geom_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 400;
   localparam int N_READS = 120;
   localparam int N_MIXED = 400;

   logic   i_clk;
   logic   i_reset;
   logic   i_req;
   addr_t  i_addr;
   wmask_t i_wmsk;
   word_t  i_wdat;
   logic   o_stall;
   logic   o_rvalid;
   word_t  o_rdata;
   logic   o_ar_valid;
   logic   i_ar_ready;
   addr_t  o_ar_addr;
   logic   i_r_valid;
   logic   o_r_ready;
   word_t  i_r_data;
   logic   i_r_last;
   logic   o_aw_valid;
   logic   i_aw_ready;
   addr_t  o_aw_addr;
   logic   o_w_valid;
   logic   i_w_ready;
   word_t  o_w_data;
   logic   o_w_last;
   logic   i_b_valid;
   logic   o_b_ready;

   int value_errs;
   int proto_errs;
   int pending;
   int aw_count;
   int tb_errs;

   // Responder memory of 1 KB
   word_t       mem [256];
   logic [15:0] stim_lfsr;
   logic [15:0] resp_lfsr;
   logic        ar_fire;
   logic        r_fire;
   logic        aw_fire;
   logic        w_fire;
   logic        b_fire;
   addr_t       ar_addr_s;
   addr_t       aw_addr_s;
   word_t       w_data_s;
   logic        rd_active;
   logic        b_pend;
   int          rd_base;
   int          rd_beat;
   int          wr_base;
   int          wr_beat;

   dcache_top #(
      .P_SETS (4),
      .P_WAYS (1)
   ) DUT (.*);

   dcache_checker u_checker (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_req        (i_req),
      .i_addr       (i_addr),
      .i_wmsk       (i_wmsk),
      .i_wdat       (i_wdat),
      .i_stall      (o_stall),
      .i_rvalid     (o_rvalid),
      .i_rdata      (o_rdata),
      .i_ar_valid   (o_ar_valid),
      .i_ar_ready   (i_ar_ready),
      .i_ar_addr    (o_ar_addr),
      .i_aw_valid   (o_aw_valid),
      .i_aw_ready   (i_aw_ready),
      .i_aw_addr    (o_aw_addr),
      .i_w_valid    (o_w_valid),
      .i_w_ready    (i_w_ready),
      .i_w_last     (o_w_last),
      .o_value_errs (value_errs),
      .o_proto_errs (proto_errs),
      .o_pending    (pending),
      .o_aw_count   (aw_count)
   );

   // Fill word mixes every bit of the word index
   function automatic word_t fill_word(input int idx);
      logic [7:0] i8;
      i8 = idx[7:0];
      return {i8, ~i8, i8 ^ 8'h3C, 8'h5A + i8};
   endfunction

   // Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
   function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
      logic [31:0] val;
      logic        nb;
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         nb = state[15] ^ state[13] ^ state[12] ^ state[10];
         state = {state[14:0], nb};
         val = {val[30:0], nb};
      end
      return val;
   endfunction

   task automatic fail_now(input string why);
      $display("%s at %0t", why, $time);
      $display("Test failures found");
      $finish;
   endtask

   // Present one request and hold it until the cache takes it
   task automatic send_request(input logic allow_write);
      logic [31:0] r;
      int          waited;
      logic        accepted;
      // A quarter of the requests go back to the previous address
      r = take_bits(stim_lfsr, 2);
      if (r[1:0] != 2'd0)
      begin
         r = take_bits(stim_lfsr, 8);
         i_addr = {22'd0, r[7:0], 2'b00};
      end
      r = take_bits(stim_lfsr, 1);
      if (allow_write && r[0])
      begin
         r = take_bits(stim_lfsr, 4);
         i_wmsk = (r[3:0] == 4'd0) ? 4'hF : r[3:0];
         r = take_bits(stim_lfsr, 32);
         i_wdat = r;
      end
      else
      begin
         i_wmsk = '0;
         i_wdat = '0;
      end
      i_req = 1'b1;
      waited = 0;
      accepted = 1'b0;
      while (!accepted && waited < TIMEOUT)
      begin
         @(negedge i_clk);
         accepted = !o_stall;
         @(posedge i_clk);
         #1;
         waited++;
      end
      if (!accepted)
         fail_now("request was never accepted by the cache");
      else
      begin
         i_req = 1'b0;
         // Occasional idle cycle between requests
         r = take_bits(stim_lfsr, 2);
         if (r[1:0] == 2'd0)
         begin
            @(posedge i_clk);
            #1;
         end
      end
   endtask

   initial
   begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   // Memory responder judges handshakes at the falling edge
   always
   begin
      logic [31:0] rb;
      @(negedge i_clk);
      ar_fire = o_ar_valid && i_ar_ready;
      r_fire = i_r_valid && o_r_ready;
      aw_fire = o_aw_valid && i_aw_ready;
      w_fire = o_w_valid && i_w_ready;
      b_fire = i_b_valid && o_b_ready;
      ar_addr_s = o_ar_addr;
      aw_addr_s = o_aw_addr;
      w_data_s = o_w_data;
      @(posedge i_clk);
      #1;
      if (ar_fire)
      begin
         rd_active = 1'b1;
         rd_base = int'(ar_addr_s[9:2]);
         rd_beat = 0;
      end
      if (r_fire)
      begin
         rd_beat++;
         if (rd_beat == 4)
            rd_active = 1'b0;
      end
      if (aw_fire)
      begin
         wr_base = int'(aw_addr_s[9:2]);
         wr_beat = 0;
      end
      if (w_fire)
      begin
         mem[(wr_base + wr_beat) % 256] = w_data_s;
         wr_beat++;
         if (wr_beat == 4)
            b_pend = 1'b1;
      end
      if (b_fire)
         b_pend = 1'b0;
      rb = take_bits(resp_lfsr, 5);
      i_ar_ready = rb[0];
      i_aw_ready = rb[1];
      i_w_ready = rb[2];
      if (!rd_active)
         i_r_valid = 1'b0;
      else if (!i_r_valid || r_fire)
         i_r_valid = rb[3];
      i_r_data = mem[(rd_base + rd_beat) % 256];
      i_r_last = rd_active && (rd_beat == 3);
      if (!b_pend)
         i_b_valid = 1'b0;
      else if (!i_b_valid)
         i_b_valid = rb[4];
   end

   initial
   begin
      int waited;
      i_reset = 1'b1;
      i_req = 1'b0;
      i_addr = '0;
      i_wmsk = '0;
      i_wdat = '0;
      i_ar_ready = 1'b0;
      i_r_valid = 1'b0;
      i_r_data = '0;
      i_r_last = 1'b0;
      i_aw_ready = 1'b0;
      i_w_ready = 1'b0;
      i_b_valid = 1'b0;
      stim_lfsr = 16'd26;
      resp_lfsr = 16'd26;
      rd_active = 1'b0;
      b_pend = 1'b0;
      rd_base = 0;
      rd_beat = 0;
      wr_base = 0;
      wr_beat = 0;
      tb_errs = 0;
      for (int i = 0; i < 256; i++)
         mem[i] = fill_word(i);
      repeat (2) @(posedge i_clk);
      #1;
      i_reset = 1'b0;
      @(negedge i_clk);
      if (o_stall || o_ar_valid || o_aw_valid || o_w_valid)
      begin
         $display("error at %0t: stall/ar/aw/w valid got %b%b%b%b expected 0000",
                  $time, o_stall, o_ar_valid, o_aw_valid, o_w_valid);
         tb_errs++;
      end
      @(posedge i_clk);
      #1;
      for (int n = 0; n < N_READS; n++)
         send_request(1'b0);
      if (aw_count != 0)
      begin
         $display("read-only traffic produced %0d write bursts", aw_count);
         tb_errs++;
      end
      for (int n = 0; n < N_MIXED; n++)
         send_request(1'b1);
      waited = 0;
      while ((pending != 0 || o_stall) && waited < TIMEOUT)
      begin
         @(posedge i_clk);
         #1;
         waited++;
      end
      if (pending != 0 || o_stall)
         fail_now("reads still pending when the run drained");
      else
      begin
         @(posedge i_clk);
         #1;
         $display("errors: %0d value, %0d protocol, %0d testbench",
                  value_errs, proto_errs, tb_errs);
         if (value_errs + proto_errs + tb_errs == 0)
            $display("All tests passed!");
         else
            $display("Test failures found");
         $finish;
      end
   end

endmodule

// ==== dv/dcache_props.sv ====
// ----------------------------------------------------------
// Controller assertions: memory valids hold until taken,
// stall low out of reset
// ----------------------------------------------------------

module dcache_props
   import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
   input logic  i_clk,
   input logic  i_reset,
   input logic  o_stall,
   input logic  o_ar_valid,
   input logic  i_ar_ready,
   input addr_t o_ar_addr,
   input logic  o_aw_valid,
   input logic  i_aw_ready,
   input addr_t o_aw_addr,
   input logic  o_w_valid,
   input logic  i_w_ready,
   input word_t o_w_data,
   input logic  o_w_last
);

   timeunit 1ns;
   timeprecision 100ps;

   a_ar_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar_addr))
      else $error("ar valid dropped before transfer");

   a_aw_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw_addr))
      else $error("aw valid dropped before transfer");

   a_w_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_w_valid && !i_w_ready |=> o_w_valid && $stable(o_w_data) && $stable(o_w_last))
      else $error("w valid or payload changed before transfer");

   a_reset_stall: assert property (@(posedge i_clk) $fell(i_reset) |-> !o_stall)
      else $error("stall high right after reset");

endmodule

bind dcache_ctrl dcache_props u_props (.*);

// ==== dv/dcache_checker.sv ====
// ----------------------------------------------------------
// Checker: reference memory, expected read queue, read data
// compare, hit timing and memory burst format checks
// ----------------------------------------------------------

module dcache_checker
   import dcache_geom_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_reset,
   input  logic   i_req,
   input  addr_t  i_addr,
   input  wmask_t i_wmsk,
   input  word_t  i_wdat,
   input  logic   i_stall,
   input  logic   i_rvalid,
   input  word_t  i_rdata,
   input  logic   i_ar_valid,
   input  logic   i_ar_ready,
   input  addr_t  i_ar_addr,
   input  logic   i_aw_valid,
   input  logic   i_aw_ready,
   input  addr_t  i_aw_addr,
   input  logic   i_w_valid,
   input  logic   i_w_ready,
   input  logic   i_w_last,
   output int     o_value_errs,
   output int     o_proto_errs,
   output int     o_pending,
   output int     o_aw_count
);

   timeunit 1ns;
   timeprecision 100ps;

   word_t             ref_mem [256];
   word_t             expect_q [$];
   int                w_beat;
   logic              lk_read;
   logic              lk_must_hit;
   logic              fill_seen;
   logic [ADDR_W-1:4] fill_line;

   function automatic word_t fill_word(input int idx);
      logic [7:0] i8;
      i8 = idx[7:0];
      return {i8, ~i8, i8 ^ 8'h3C, 8'h5A + i8};
   endfunction

   initial
   begin
      o_value_errs = 0;
      o_proto_errs = 0;
      o_pending = 0;
      o_aw_count = 0;
      w_beat = 0;
      lk_read = 1'b0;
      lk_must_hit = 1'b0;
      fill_seen = 1'b0;
      fill_line = '0;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = fill_word(i);
   end

   // Everything is stable at the falling edge
   always @(negedge i_clk)
   begin
      int    idx;
      word_t exp_data;
      if (!i_reset)
      begin
         // New request in its lookup cycle answers at once unless it missed
         if (lk_read && !i_stall && !i_rvalid)
         begin
            $display("error at %0t: o_rvalid got 0 expected 1", $time);
            o_proto_errs++;
         end
         if (lk_must_hit && i_stall)
         begin
            $display("error at %0t: o_stall got 1 expected 0", $time);
            o_proto_errs++;
         end
         lk_read = 1'b0;
         lk_must_hit = 1'b0;
         if (i_rvalid)
         begin
            if (expect_q.size() == 0)
            begin
               $display("o_rvalid at %0t with no read outstanding", $time);
               o_proto_errs++;
            end
            else
            begin
               exp_data = expect_q.pop_front();
               if (i_rdata !== exp_data)
               begin
                  $display("error at %0t: o_rdata got %h expected %h",
                           $time, i_rdata, exp_data);
                  o_value_errs++;
               end
            end
         end
         // Request taken at the coming rising edge
         if (i_req && !i_stall)
         begin
            idx = int'(i_addr[9:2]);
            lk_read = (i_wmsk == '0);
            lk_must_hit = fill_seen && (i_addr[ADDR_W-1:4] == fill_line);
            fill_seen = 1'b0;
            if (i_wmsk == '0)
               expect_q.push_back(ref_mem[idx]);
            else
               for (int b = 0; b < 4; b++)
                  if (i_wmsk[b])
                     ref_mem[idx][b*8 +: 8] = i_wdat[b*8 +: 8];
         end
         if (i_ar_valid && i_ar_ready)
         begin
            // First request taken after this refill finds the line present
            fill_seen = 1'b1;
            fill_line = i_ar_addr[ADDR_W-1:4];
            if (i_ar_addr[3:0] != 4'd0)
            begin
               $display("read burst address %h at %0t is not line aligned",
                        i_ar_addr, $time);
               o_proto_errs++;
            end
         end
         if (i_aw_valid && i_aw_ready)
         begin
            o_aw_count++;
            if (i_aw_addr[3:0] != 4'd0)
            begin
               $display("write burst address %h at %0t is not line aligned",
                        i_aw_addr, $time);
               o_proto_errs++;
            end
         end
         if (i_w_valid && i_w_ready)
         begin
            if (i_w_last !== (w_beat == 3))
            begin
               $display("error at %0t: o_w_last got %b expected %b",
                        $time, i_w_last, w_beat == 3);
               o_proto_errs++;
            end
            w_beat = (w_beat + 1) % 4;
         end
         o_pending = expect_q.size();
      end
   end

endmodule

// ==== verilog/dcache_top.sv ====
// ----------------------------------------------------------
// Data cache top level: request stage, generated ways
// and the miss controller
// ----------------------------------------------------------

module dcache_top
   import dcache_geom_pkg::*;
#(
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
)
(
   input  logic   i_clk,
   input  logic   i_reset,
   input  logic   i_req,
   input  addr_t  i_addr,
   input  wmask_t i_wmsk,
   input  word_t  i_wdat,
   output logic   o_stall,
   output logic   o_rvalid,
   output word_t  o_rdata,
   output logic   o_ar_valid,
   input  logic   i_ar_ready,
   output addr_t  o_ar_addr,
   input  logic   i_r_valid,
   output logic   o_r_ready,
   input  word_t  i_r_data,
   input  logic   i_r_last,
   output logic   o_aw_valid,
   input  logic   i_aw_ready,
   output addr_t  o_aw_addr,
   output logic   o_w_valid,
   input  logic   i_w_ready,
   output word_t  o_w_data,
   output logic   o_w_last,
   input  logic   i_b_valid,
   output logic   o_b_ready
);

   localparam int NWAYS = 1 << P_WAYS;

   logic              lk_valid;
   addr_t             lk_addr;
   wmask_t            lk_wmsk;
   word_t             lk_wdat;
   logic [P_SETS-1:0] rd_index;
   word_sel_t         rd_word;
   logic [NWAYS-1:0]  hit_vec;
   logic [NWAYS-1:0]  dirty_vec;
   logic [NWAYS-1:0]  tag_we;
   logic [NWAYS-1:0]  dirty_set;
   logic [NWAYS-1:0]  dirty_clr;
   addr_t             way_tag_addr [NWAYS];
   word_t             way_rdata [NWAYS];
   wmask_t            data_we [NWAYS];
   word_sel_t         wr_word;
   word_t             wr_data;

   // Stall doubles as the pipeline hold
   dcache_req_stage #(
      .P_SETS      (P_SETS)
   ) u_req_stage (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_req       (i_req),
      .i_addr      (i_addr),
      .i_wmsk      (i_wmsk),
      .i_wdat      (i_wdat),
      .i_hold      (o_stall),
      .o_lk_valid  (lk_valid),
      .o_lk_addr   (lk_addr),
      .o_lk_wmsk   (lk_wmsk),
      .o_lk_wdat   (lk_wdat),
      .o_rd_index  (rd_index),
      .o_rd_word   (rd_word)
   );

   for (genvar g = 0; g < NWAYS; g++)
   begin : gen_way
      dcache_way #(
         .P_SETS      (P_SETS)
      ) u_way (
         .i_clk       (i_clk),
         .i_reset     (i_reset),
         .i_rd_index  (rd_index),
         .i_rd_word   (rd_word),
         .i_lk_addr   (lk_addr),
         .i_data_we   (data_we[g]),
         .i_wr_word   (wr_word),
         .i_wr_data   (wr_data),
         .i_tag_we    (tag_we[g]),
         .i_dirty_set (dirty_set[g]),
         .i_dirty_clr (dirty_clr[g]),
         .o_hit       (hit_vec[g]),
         .o_dirty     (dirty_vec[g]),
         .o_tag_addr  (way_tag_addr[g]),
         .o_rdata     (way_rdata[g])
      );
   end

   dcache_ctrl #(
      .P_WAYS         (P_WAYS)
   ) u_ctrl (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_lk_valid     (lk_valid),
      .i_lk_addr      (lk_addr),
      .i_lk_wmsk      (lk_wmsk),
      .i_lk_wdat      (lk_wdat),
      .i_hit_vec      (hit_vec),
      .i_dirty_vec    (dirty_vec),
      .i_way_tag_addr (way_tag_addr),
      .i_way_rdata    (way_rdata),
      .o_stall        (o_stall),
      .o_rvalid       (o_rvalid),
      .o_rdata        (o_rdata),
      .o_data_we      (data_we),
      .o_wr_word      (wr_word),
      .o_wr_data      (wr_data),
      .o_tag_we       (tag_we),
      .o_dirty_set    (dirty_set),
      .o_dirty_clr    (dirty_clr),
      .o_ar_valid     (o_ar_valid),
      .i_ar_ready     (i_ar_ready),
      .o_ar_addr      (o_ar_addr),
      .i_r_valid      (i_r_valid),
      .o_r_ready      (o_r_ready),
      .i_r_data       (i_r_data),
      .i_r_last       (i_r_last),
      .o_aw_valid     (o_aw_valid),
      .i_aw_ready     (i_aw_ready),
      .o_aw_addr      (o_aw_addr),
      .o_w_valid      (o_w_valid),
      .i_w_ready      (i_w_ready),
      .o_w_data       (o_w_data),
      .o_w_last       (o_w_last),
      .i_b_valid      (i_b_valid),
      .o_b_ready      (o_b_ready)
   );

endmodule

// ==== verilog/dcache_ctrl.sv ====
// ----------------------------------------------------------
// Cache controller: hit select, hit writes, round-robin
// victim, miss FSM with writeback and refill bursts
// ----------------------------------------------------------

module dcache_ctrl
   import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
#(
   parameter int P_WAYS = 1
)
(
   input  logic                i_clk,
   input  logic                i_reset,
   input  logic                i_lk_valid,
   input  addr_t               i_lk_addr,
   input  wmask_t              i_lk_wmsk,
   input  word_t               i_lk_wdat,
   input  logic [(1<<P_WAYS)-1:0] i_hit_vec,
   input  logic [(1<<P_WAYS)-1:0] i_dirty_vec,
   input  addr_t               i_way_tag_addr [1<<P_WAYS],
   input  word_t               i_way_rdata [1<<P_WAYS],
   output logic                o_stall,
   output logic                o_rvalid,
   output word_t               o_rdata,
   output wmask_t              o_data_we [1<<P_WAYS],
   output word_sel_t           o_wr_word,
   output word_t               o_wr_data,
   output logic [(1<<P_WAYS)-1:0] o_tag_we,
   output logic [(1<<P_WAYS)-1:0] o_dirty_set,
   output logic [(1<<P_WAYS)-1:0] o_dirty_clr,
   output logic                o_ar_valid,
   input  logic                i_ar_ready,
   output addr_t               o_ar_addr,
   input  logic                i_r_valid,
   output logic                o_r_ready,
   input  word_t               i_r_data,
   input  logic                i_r_last,
   output logic                o_aw_valid,
   input  logic                i_aw_ready,
   output addr_t               o_aw_addr,
   output logic                o_w_valid,
   input  logic                i_w_ready,
   output word_t               o_w_data,
   output logic                o_w_last,
   input  logic                i_b_valid,
   output logic                o_b_ready
);

   localparam int NWAYS = 1 << P_WAYS;
   localparam int BYTE_OFS = $clog2(WORD_W / 8);
   localparam int OFS_W = P_LINE_WORDS + BYTE_OFS;

   ctrl_state_e      state_q;
   ctrl_state_e      state_nxt;
   logic [NWAYS-1:0] victim_q;
   word_sel_t        beat_q;
   word_sel_t        beat_nxt;
   logic             lookup;
   logic             hit;
   logic             miss;
   logic             lk_write;
   logic             draining;
   logic             victim_dirty;
   addr_t            victim_tag_addr;
   word_t            victim_rdata;
   logic             ar_fire;
   logic             r_fire;
   logic             aw_fire;
   logic             w_fire;
   logic             b_fire;
   logic             refill_done;

   // Reload acts as one more lookup cycle for the held request
   assign lookup = (state_q == S_IDLE) || (state_q == S_RELOAD);
   assign hit = |i_hit_vec;
   assign lk_write = |i_lk_wmsk;
   assign miss = (state_q == S_IDLE) && i_lk_valid && !hit;
   assign draining = (state_q == S_WB_ADDR) || (state_q == S_WB_DATA);

   assign o_stall = !lookup || miss;
   assign o_rvalid = lookup && i_lk_valid && hit && !lk_write;

   // Way muxes for the hit word and the victim
   always_comb
   begin
      o_rdata = '0;
      victim_rdata = '0;
      victim_tag_addr = '0;
      for (int w = 0; w < NWAYS; w++)
      begin
         if (i_hit_vec[w])
            o_rdata |= i_way_rdata[w];
         if (victim_q[w])
         begin
            victim_rdata |= i_way_rdata[w];
            victim_tag_addr |= i_way_tag_addr[w];
         end
      end
   end

   assign victim_dirty = |(i_dirty_vec & victim_q);

   // Memory channels
   assign o_ar_valid = (state_q == S_REFILL_ADDR);
   assign o_ar_addr = {i_lk_addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
   assign o_r_ready = (state_q == S_REFILL_DATA);
   assign o_aw_valid = (state_q == S_WB_ADDR);
   assign o_aw_addr = victim_tag_addr;
   assign o_w_valid = (state_q == S_WB_DATA);
   assign o_w_data = victim_rdata;
   assign o_w_last = o_w_valid && (beat_q == BURST_LAST);
   assign o_b_ready = (state_q == S_WB_RESP);

   assign ar_fire = o_ar_valid & i_ar_ready;
   assign r_fire = o_r_ready & i_r_valid;
   assign aw_fire = o_aw_valid & i_aw_ready;
   assign w_fire = o_w_valid & i_w_ready;
   assign b_fire = o_b_ready & i_b_valid;
   assign refill_done = r_fire & i_r_last;

   // Beat counter wraps to zero after each burst
   assign beat_nxt = (w_fire || r_fire) ? beat_q + 1'b1 : beat_q;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         S_IDLE:
            if (miss)
               state_nxt = victim_dirty ? S_WB_ADDR : S_REFILL_ADDR;
         S_WB_ADDR:
            if (aw_fire)
               state_nxt = S_WB_DATA;
         S_WB_DATA:
            if (w_fire && o_w_last)
               state_nxt = S_WB_RESP;
         S_WB_RESP:
            if (b_fire)
               state_nxt = S_REFILL_ADDR;
         S_REFILL_ADDR:
            if (ar_fire)
               state_nxt = S_REFILL_DATA;
         S_REFILL_DATA:
            if (refill_done)
               state_nxt = S_RELOAD;
         default:
            state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge i_clk)
   begin
      if (i_reset)
      begin
         state_q <= S_IDLE;
         beat_q <= '0;
         victim_q <= NWAYS'(1);
      end
      else
      begin
         state_q <= state_nxt;
         beat_q <= beat_nxt;
         // Next victim once the refill has landed
         if (refill_done)
            victim_q <= (victim_q << 1) | (victim_q >> (NWAYS - 1));
      end
   end

   // Array controls per way
   always_comb
   begin
      for (int w = 0; w < NWAYS; w++)
      begin
         o_data_we[w] = '0;
         if (lookup && i_lk_valid && i_hit_vec[w])
            o_data_we[w] = i_lk_wmsk;
         if (r_fire && victim_q[w])
            o_data_we[w] = '1;
         o_tag_we[w] = refill_done & victim_q[w];
         o_dirty_set[w] = lookup & i_lk_valid & i_hit_vec[w] & lk_write;
         o_dirty_clr[w] = draining & victim_q[w];
      end
   end

   // Writeback reads one word ahead of the W channel
   assign o_wr_word = r_fire ? beat_q :
                      draining ? beat_nxt : i_lk_addr[BYTE_OFS +: P_LINE_WORDS];
   assign o_wr_data = r_fire ? i_r_data : i_lk_wdat;

endmodule

// ==== verilog/dcache_way.sv ====
// ----------------------------------------------------------
// One cache way: tag, valid and dirty flops per set, a
// byte-writable data array and the hit compare
// ----------------------------------------------------------

module dcache_way
   import dcache_geom_pkg::*;
#(
   parameter int P_SETS = 4
)
(
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic [P_SETS-1:0] i_rd_index,
   input  word_sel_t         i_rd_word,
   input  addr_t             i_lk_addr,
   input  wmask_t            i_data_we,
   input  word_sel_t         i_wr_word,
   input  word_t             i_wr_data,
   input  logic              i_tag_we,
   input  logic              i_dirty_set,
   input  logic              i_dirty_clr,
   output logic              o_hit,
   output logic              o_dirty,
   output addr_t             o_tag_addr,
   output word_t             o_rdata
);

   localparam int BYTE_OFS = $clog2(WORD_W / 8);
   localparam int OFS_W = P_LINE_WORDS + BYTE_OFS;
   localparam int TAG_W = ADDR_W - P_SETS - OFS_W;
   localparam int SETS = 1 << P_SETS;
   localparam int AW = P_SETS + P_LINE_WORDS;

   typedef logic [TAG_W-1:0] tag_t;

   tag_t              tag_q [SETS];
   logic [SETS-1:0]   valid_q;
   logic [SETS-1:0]   dirty_q;
   word_t             mem [SETS*LINE_WORDS];
   word_t             rdata_q;
   word_t             fwd_data;
   logic [P_SETS-1:0] lk_index;
   tag_t              lk_tag;
   word_sel_t         rd_word;
   logic [AW-1:0]     rd_addr;
   logic [AW-1:0]     wr_addr;

   assign lk_index = i_lk_addr[OFS_W +: P_SETS];
   assign lk_tag = i_lk_addr[ADDR_W-1 -: TAG_W];

   always_ff @(posedge i_clk)
   begin
      if (i_reset)
      begin
         valid_q <= '0;
         dirty_q <= '0;
         for (int s = 0; s < SETS; s++)
            tag_q[s] <= '0;
      end
      else if (i_tag_we)
      begin
         // New line arrives clean
         tag_q[lk_index] <= lk_tag;
         valid_q[lk_index] <= 1'b1;
         dirty_q[lk_index] <= 1'b0;
      end
      else if (i_dirty_set)
         dirty_q[lk_index] <= 1'b1;
      else if (i_dirty_clr)
         dirty_q[lk_index] <= 1'b0;
   end

   // While its line drains, the array reads the word the controller points at
   assign rd_word = i_dirty_clr ? i_wr_word : i_rd_word;
   assign rd_addr = {i_rd_index, rd_word};
   assign wr_addr = {lk_index, i_wr_word};

   // Same-edge write bypass into the read register
   always_comb
   begin
      fwd_data = mem[rd_addr];
      if (rd_addr == wr_addr)
      begin
         for (int b = 0; b < WORD_W / 8; b++)
         begin
            if (i_data_we[b])
               fwd_data[b*8 +: 8] = i_wr_data[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge i_clk)
   begin
      for (int b = 0; b < WORD_W / 8; b++)
      begin
         if (i_data_we[b])
            mem[wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
      end
      rdata_q <= fwd_data;
   end

   assign o_hit = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
   assign o_dirty = valid_q[lk_index] & dirty_q[lk_index];
   assign o_tag_addr = {tag_q[lk_index], lk_index, {OFS_W{1'b0}}};
   assign o_rdata = rdata_q;

endmodule

// ==== verilog/dcache_req_stage.sv ====
// ----------------------------------------------------------
// Request stage: captures processor requests into the
// lookup stage and picks the array read address
// ----------------------------------------------------------

module dcache_req_stage
   import dcache_geom_pkg::*;
#(
   parameter int P_SETS = 4
)
(
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_req,
   input  addr_t             i_addr,
   input  wmask_t            i_wmsk,
   input  word_t             i_wdat,
   input  logic              i_hold,
   output logic              o_lk_valid,
   output addr_t             o_lk_addr,
   output wmask_t            o_lk_wmsk,
   output word_t             o_lk_wdat,
   output logic [P_SETS-1:0] o_rd_index,
   output word_sel_t         o_rd_word
);

   localparam int BYTE_OFS = $clog2(WORD_W / 8);
   localparam int OFS_W = P_LINE_WORDS + BYTE_OFS;

   addr_t rd_addr;

   always_ff @(posedge i_clk)
   begin
      if (i_reset)
         o_lk_valid <= 1'b0;
      else if (!i_hold)
         o_lk_valid <= i_req;
   end

   // Payload follows the valid bit
   always_ff @(posedge i_clk)
   begin
      if (!i_hold)
      begin
         o_lk_addr <= i_addr;
         o_lk_wmsk <= i_wmsk;
         o_lk_wdat <= i_wdat;
      end
   end

   // Held request keeps the arrays pointed at its own word
   assign rd_addr = i_hold ? o_lk_addr : i_addr;

   assign o_rd_index = rd_addr[OFS_W +: P_SETS];
   assign o_rd_word = rd_addr[BYTE_OFS +: P_LINE_WORDS];

endmodule

// ==== verilog/dcache_ctrl_pkg.sv ====
// ----------------------------------------------------------
// Data cache controller: miss FSM states and burst length
// ----------------------------------------------------------

package dcache_ctrl_pkg;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WB_ADDR,
      S_WB_DATA,
      S_WB_RESP,
      S_REFILL_ADDR,
      S_REFILL_DATA,
      S_RELOAD
   } ctrl_state_e;

   // Index of the fourth beat of a line burst
   localparam logic [1:0] BURST_LAST = 2'd3;

endpackage

// ==== verilog/dcache_geom_pkg.sv ====
// ----------------------------------------------------------
// Data cache geometry: address, word and line constants
// and the vector types built on them
// ----------------------------------------------------------

package dcache_geom_pkg;

   // Byte address and data word
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // Four words per line
   localparam int P_LINE_WORDS = 2;
   localparam int LINE_WORDS = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // One enable bit per byte lane
   typedef logic [WORD_W/8-1:0] wmask_t;

   // Word position inside a line
   typedef logic [P_LINE_WORDS-1:0] word_sel_t;

endpackage
